// ==== vlog.f ====
+incdir+verilog
verilog/rvx_pkg.sv
verilog/op_decoder.sv
verilog/alu.sv
verilog/load_unit.sv
verilog/stage_reg.sv
verilog/exec_core.sv
bench/exec_core_props.sv
bench/exec_core_tb.sv

// ==== run.sh ====
#!/bin/bash
# builds the exec_core testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module exec_core_tb -Mdir obj_dir -o exec_core_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/exec_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== bench/exec_core_tb.sv ====
`timescale 1ns/1ps
`include "rvx_cfg.svh"

module exec_core_tb;

    localparam int half_period     = 20;
    localparam int reset_cycles    = 5;
    localparam int preload_words   = 32;
    localparam int num_instr       = 400;
    localparam int watchdog_cycles = reset_cycles + preload_words + num_instr * 2 + 50;

    logic                    clk;
    logic                    reset;
    logic                    in_valid;
    logic [31:0]             instr;
    logic [`RVX_XLEN-1:0]    rs1_val;
    logic [`RVX_XLEN-1:0]    rs2_val;
    logic                    mem_we;
    logic [`RVX_DMEM_AW-1:0] mem_addr;
    logic [`RVX_XLEN-1:0]    mem_wdata;
    logic                    out_valid;
    logic [4:0]              rd;
    logic                    rd_we;
    logic [`RVX_XLEN-1:0]    result;
    logic                    branch_taken;

    logic [31:0] lfsr;
    int unsigned issued;
    int unsigned received;
    int unsigned tb_errors;
    bit          finished;

    exec_core u_exec_core (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .instr        (instr),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .out_valid    (out_valid),
        .rd           (rd),
        .rd_we        (rd_we),
        .result       (result),
        .branch_taken (branch_taken)
    );

    bind exec_core exec_core_props u_props (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .instr        (instr),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .out_valid    (out_valid),
        .rd           (rd),
        .rd_we        (rd_we),
        .result       (result),
        .branch_taken (branch_taken)
    );

    initial clk = 1'b0;
    always #half_period clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[62:0], fb};
        end
        return val;
    endfunction

    function automatic logic [9:0] op_funct(input logic [3:0] sel);
        case (sel)
            4'd0:    return {7'h00, 3'b000};  // add
            4'd1:    return {7'h20, 3'b000};  // sub
            4'd2:    return {7'h00, 3'b001};  // sll
            4'd3:    return {7'h00, 3'b011};  // sltu
            4'd4:    return {7'h00, 3'b100};
            4'd5:    return {7'h20, 3'b101};  // sra
            4'd6:    return {7'h00, 3'b110};
            4'd7:    return {7'h00, 3'b111};
            4'd8:    return {7'h01, 3'b000};  // mul
            4'd13:   return {7'h00, 3'b001};
            4'd14:   return {7'h20, 3'b101};
            default: return {7'h01, 3'b111};  // remu
        endcase
    endfunction

    task automatic print_counts();
        $display("errors: testbench %0d, assertions %0d", tb_errors,
                 u_exec_core.u_props.fail_cnt);
    endtask

    task automatic preload_memory();
        for (int i = 0; i < preload_words; i++) begin
            @(negedge clk);
            mem_we    = 1'b1;
            mem_addr  = i[`RVX_DMEM_AW-1:0];
            mem_wdata = take_bits(64);
        end
        @(negedge clk);
        mem_we = 1'b0;
    endtask

    task automatic issue_random();
        logic [63:0] r;
        logic [63:0] a;
        logic [63:0] b;
        logic [4:0]  rdf;
        logic [4:0]  rs1f;
        logic [4:0]  rs2f;
        logic [11:0] imm;
        logic [3:0]  sel;
        logic [2:0]  f3;
        logic [9:0]  fr;
        logic [7:0]  target;
        logic [31:0] ins;
        r = take_bits(2);
        if (r[1:0] == 2'b00) begin
            @(negedge clk);
            in_valid = 1'b0;  // idle gap
        end
        r    = take_bits(15);
        rdf  = r[4:0];
        rs1f = r[9:5];
        rs2f = r[14:10];
        a    = take_bits(64);
        b    = take_bits(64);
        r    = take_bits(12);
        imm  = r[11:0];
        r    = take_bits(4);
        sel  = r[3:0];
        r    = take_bits(3);
        case (r[2:0])
            3'd0: begin
                fr = op_funct(sel);
                if (sel == 4'd10 || sel == 4'd11) begin
                    b = '0;  // remu by zero
                end
                ins = {fr[9:3], rs2f, rs1f, fr[2:0], rdf, 7'h33};
            end
            3'd1: begin
                f3 = sel[2:0];
                if (f3 == 3'b010) begin
                    f3 = 3'b011;
                end
                if (f3 == 3'b001) begin
                    imm = {6'b000000, imm[5:0]};
                end else if (f3 == 3'b101) begin
                    imm = {6'b010000, imm[5:0]};
                end
                ins = {imm, rs1f, f3, rdf, 7'h13};
            end
            3'd2: ins = {7'h00, rs2f, rs1f, 2'b00, sel[0], rdf, 7'h3b};
            3'd3: begin
                if (sel[0]) begin
                    ins = {7'h00, imm[4:0], rs1f, 3'b001, rdf, 7'h1b};
                end else begin
                    ins = {imm, rs1f, 3'b000, rdf, 7'h1b};
                end
            end
            3'd4, 3'd5: begin
                r      = take_bits(8);
                target = r[7:0];
                f3     = 3'b100;
                if (sel[1:0] == 2'd1) begin
                    f3          = 3'b110;
                    target[1:0] = 2'b00;
                end else if (sel[1:0] == 2'd2) begin
                    f3          = 3'b011;
                    target[2:0] = 3'b000;
                end
                a   = {56'd0, target} - {{52{imm[11]}}, imm};  // lands in preloaded words
                ins = {imm, rs1f, f3, rdf, 7'h03};
            end
            3'd6: begin
                f3 = (sel[1:0] == 2'd1) ? 3'b001 : (sel[1:0] == 2'd2) ? 3'b100 : 3'b000;
                if (sel[2]) begin
                    b = a;
                end
                ins = {imm[11:5], rs2f, rs1f, f3, imm[4:0], 7'h63};
            end
            default: begin
                r   = take_bits(20);
                ins = {r[19:0], rdf, 7'h37};
            end
        endcase
        @(negedge clk);
        in_valid = 1'b1;
        instr    = ins;
        rs1_val  = a;
        rs2_val  = b;
        issued++;
    endtask

    always @(negedge clk) begin
        if (!reset && out_valid) begin
            received <= received + 1;
        end
    end

    initial begin
        lfsr      = 32'h8a1e_d0be;
        reset     = 1'b1;
        in_valid  = 1'b0;
        instr     = '0;
        rs1_val   = '0;
        rs2_val   = '0;
        mem_we    = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        issued    = 0;
        received  = 0;
        tb_errors = 0;
        finished  = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        preload_memory();
        for (int n = 0; n < num_instr; n++) begin
            issue_random();
        end
        @(negedge clk);
        in_valid = 1'b0;
        repeat (3) @(negedge clk);  // drain the two stages
        if (received != issued) begin
            $display("Fail %0t out_valid count exp %0d got %0d", $time, issued, received);
            tb_errors++;
        end
        print_counts();
        if (tb_errors == 0 && u_exec_core.u_props.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        finished = 1'b1;
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        print_counts();
        $display("TEST FAIL");
        finished = 1'b1;
        $finish;
    end

    final begin
        if (!finished) begin
            $display("the run was stopped before the end of the test");
            print_counts();
            $display("TEST FAIL");
        end
    end

endmodule

// ==== bench/exec_core_props.sv ====
`timescale 1ns/1ps
`include "rvx_cfg.svh"

module exec_core_props (
    input logic                    clk,
    input logic                    reset,
    input logic                    in_valid,
    input logic [31:0]             instr,
    input logic [`RVX_XLEN-1:0]    rs1_val,
    input logic [`RVX_XLEN-1:0]    rs2_val,
    input logic                    mem_we,
    input logic [`RVX_DMEM_AW-1:0] mem_addr,
    input logic [`RVX_XLEN-1:0]    mem_wdata,
    input logic                    out_valid,
    input logic [4:0]              rd,
    input logic                    rd_we,
    input logic [`RVX_XLEN-1:0]    result,
    input logic                    branch_taken
);

    logic [63:0] shadow [`RVX_DMEM_DEPTH];
    logic [63:0] imm_i;
    logic [63:0] ld_addr;
    logic [63:0] ld_dw;
    logic [63:0] ld_shift;
    logic [63:0] w_b;
    logic [31:0] w_sum;
    logic [31:0] w_shl;
    logic [63:0] nxt_res;
    logic        nxt_we;
    logic        nxt_br;
    logic [1:0]  pv;  // bit 1 is the record due at the outputs
    logic [1:0]  pwe;
    logic [1:0]  pbr;
    logic [4:0]  prd [2];
    logic [63:0] pres [2];
    int unsigned fail_cnt = 0;

    // OP and OP-IMM rules where funct7 bit 0 picks the M extension
    function automatic logic [63:0] int_rule(input logic [2:0] f3, input logic alt,
                                             input logic mext, input logic [63:0] a,
                                             input logic [63:0] b);
        if (mext) begin
            if (f3 == 3'b000) begin
                return a * b;
            end
            return (b == 64'd0) ? a : a % b;  // remu by zero keeps the dividend
        end
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b011:  return {63'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return $signed(a) >>> b[5:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    assign imm_i = {{52{instr[31]}}, instr[31:20]};

    always_comb begin
        ld_addr  = rs1_val + imm_i;
        ld_dw    = shadow[ld_addr[`RVX_DMEM_AW+2:3]];
        ld_shift = ld_dw >> {ld_addr[2:0], 3'b000};
        w_b      = instr[5] ? rs2_val : imm_i;  // bit 5 splits OP-32 from OP-IMM-32
        w_sum    = rs1_val[31:0] + w_b[31:0];
        w_shl    = rs1_val[31:0] << w_b[4:0];
        nxt_res  = '0;
        nxt_we   = 1'b1;
        nxt_br   = 1'b0;
        case (instr[6:0])
            7'h33: nxt_res = int_rule(instr[14:12], instr[30], instr[25], rs1_val, rs2_val);
            7'h13: nxt_res = int_rule(instr[14:12], 1'b0, 1'b0, rs1_val, imm_i);
            7'h3b, 7'h1b: nxt_res = {32'd0, (instr[14:12] == 3'b001) ? w_shl : w_sum};
            7'h03: begin
                case (instr[14:12])
                    3'b100:  nxt_res = {56'd0, ld_shift[7:0]};
                    3'b110:  nxt_res = {32'd0, ld_addr[2] ? ld_dw[63:32] : ld_dw[31:0]};
                    default: nxt_res = ld_dw;
                endcase
            end
            7'h63: begin
                nxt_we = 1'b0;
                case (instr[14:12])
                    3'b000:  nxt_br = (rs1_val == rs2_val);
                    3'b001:  nxt_br = (rs1_val != rs2_val);
                    default: nxt_br = ($signed(rs1_val) < $signed(rs2_val));
                endcase
            end
            7'h37:   nxt_res = {{32{instr[31]}}, instr[31:12], 12'd0};
            default: nxt_we = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        if (mem_we) begin
            shadow[mem_addr] <= mem_wdata;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            pv <= 2'b00;
        end else begin
            pv <= {pv[0], in_valid};
        end
        pwe     <= {pwe[0], nxt_we};
        pbr     <= {pbr[0], nxt_br};
        prd[1]  <= prd[0];
        prd[0]  <= instr[11:7];
        pres[1] <= pres[0];
        pres[0] <= nxt_res;
    end

    a_out_valid: assert property (@(posedge clk) disable iff (reset) out_valid == pv[1])
    else begin
        fail_cnt++;
        $error("Fail %0t out_valid exp %b got %b", $time, $sampled(pv[1]), $sampled(out_valid));
    end

    a_rd_we: assert property (@(posedge clk) disable iff (reset) rd_we == (pv[1] && pwe[1]))
    else begin
        fail_cnt++;
        $error("Fail %0t rd_we exp %b got %b", $time, $sampled(pv[1] && pwe[1]),
               $sampled(rd_we));
    end

    a_rd: assert property (@(posedge clk) disable iff (reset)
        (out_valid && pwe[1]) |-> rd == prd[1])
    else begin
        fail_cnt++;
        $error("Fail %0t rd exp %0d got %0d", $time, $sampled(prd[1]), $sampled(rd));
    end

    a_result: assert property (@(posedge clk) disable iff (reset)
        (out_valid && pwe[1]) |-> result == pres[1])
    else begin
        fail_cnt++;
        $error("Fail %0t result exp %h got %h", $time, $sampled(pres[1]), $sampled(result));
    end

    a_result_idle: assert property (@(posedge clk) !out_valid |-> result == '0)
    else begin
        fail_cnt++;
        $error("Fail %0t result exp 0 got %h", $time, $sampled(result));
    end

    a_branch: assert property (@(posedge clk) disable iff (reset)
        branch_taken == (pv[1] && pbr[1]))
    else begin
        fail_cnt++;
        $error("Fail %0t branch_taken exp %b got %b", $time, $sampled(pv[1] && pbr[1]),
               $sampled(branch_taken));
    end

endmodule

// ==== verilog/exec_core.sv ====
`timescale 1ns/1ps
`include "rvx_cfg.svh"

module exec_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  logic [31:0]             instr,
    input  logic [`RVX_XLEN-1:0]    rs1_val,
    input  logic [`RVX_XLEN-1:0]    rs2_val,
    input  logic                    mem_we,
    input  logic [`RVX_DMEM_AW-1:0] mem_addr,
    input  logic [`RVX_XLEN-1:0]    mem_wdata,
    output logic                    out_valid,
    output logic [4:0]              rd,
    output logic                    rd_we,
    output logic [`RVX_XLEN-1:0]    result,
    output logic                    branch_taken
);
    import rvx_pkg::*;

    alu_op_e              dec_op;
    logic [`RVX_XLEN-1:0] dec_a;
    logic [`RVX_XLEN-1:0] dec_b;
    load_kind_e           dec_kind;
    logic [4:0]           dec_rd;
    logic                 dec_we;

    ex_req_t              ex_d;
    ex_req_t              ex_q;
    logic                 ex_valid;

    logic [`RVX_XLEN-1:0] alu_res;
    logic                 alu_cmp;

    wb_t                  wb_d;
    wb_t                  wb_q;
    logic                 wb_valid;
    logic [`RVX_XLEN-1:0] load_data;

    op_decoder u_dec (
        .instr     (instr),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .alu_op    (dec_op),
        .op_a      (dec_a),
        .op_b      (dec_b),
        .load_kind (dec_kind),
        .rd        (dec_rd),
        .rd_we     (dec_we)
    );

    assign ex_d.alu_op    = dec_op;
    assign ex_d.op_a      = dec_a;
    assign ex_d.op_b      = dec_b;
    assign ex_d.load_kind = dec_kind;
    assign ex_d.rd        = dec_rd;
    assign ex_d.rd_we     = dec_we;

    stage_reg #(.payload_t(ex_req_t)) u_ex (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (ex_d),
        .out_valid (ex_valid),
        .out_data  (ex_q)
    );

    alu u_alu (
        .alu_op  (ex_q.alu_op),
        .src1    (ex_q.op_a),
        .src2    (ex_q.op_b),
        .alu_res (alu_res),
        .cmp     (alu_cmp)
    );

    assign wb_d.alu_res   = alu_res;
    assign wb_d.branch    = alu_cmp;
    assign wb_d.load_kind = ex_q.load_kind;
    assign wb_d.byte_off  = alu_res[2:0];
    assign wb_d.rd        = ex_q.rd;
    assign wb_d.rd_we     = ex_q.rd_we;

    // memory read lines up with the u_wb capture
    load_unit u_load (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .rd_addr   (alu_res[`RVX_DMEM_AW+2:3]),
        .load_kind (wb_q.load_kind),
        .byte_off  (wb_q.byte_off),
        .load_data (load_data)
    );

    stage_reg #(.payload_t(wb_t)) u_wb (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ex_valid),
        .in_data   (wb_d),
        .out_valid (wb_valid),
        .out_data  (wb_q)
    );

    assign out_valid    = wb_valid;
    assign rd           = wb_q.rd;
    assign rd_we        = wb_valid & wb_q.rd_we;
    assign branch_taken = wb_valid & wb_q.branch;

    always_comb begin
        if (!wb_valid) begin
            result = '0;  // quiet between records
        end else if (wb_q.load_kind != ld_none) begin
            result = load_data;
        end else begin
            result = wb_q.alu_res;
        end
    end

endmodule

// ==== verilog/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload follows valid without enable
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

// ==== verilog/load_unit.sv ====
`timescale 1ns/1ps
`include "rvx_cfg.svh"

module load_unit (
    input  logic                    clk,
    input  logic                    mem_we,
    input  logic [`RVX_DMEM_AW-1:0] mem_addr,
    input  logic [`RVX_XLEN-1:0]    mem_wdata,
    input  logic [`RVX_DMEM_AW-1:0] rd_addr,
    input  rvx_pkg::load_kind_e     load_kind,
    input  logic [2:0]              byte_off,
    output logic [`RVX_XLEN-1:0]    load_data
);
    import rvx_pkg::*;

    logic [`RVX_XLEN-1:0] mem [`RVX_DMEM_DEPTH];
    logic [`RVX_XLEN-1:0] rd_q;
    logic [7:0]           rd_byte;
    logic [31:0]          rd_word;

    // preload port and load read share the edge
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        rd_q <= mem[rd_addr];  // old data on a same-address write
    end

    assign rd_byte = rd_q[{byte_off, 3'b000} +: 8];

    // words are taken from the aligned half
    assign rd_word = byte_off[2] ? rd_q[63:32] : rd_q[31:0];

    always_comb begin
        case (load_kind)
            ld_bu: begin
                load_data = {{(`RVX_XLEN-8){1'b0}}, rd_byte};
            end
            ld_wu: begin
                load_data = {{(`RVX_XLEN-32){1'b0}}, rd_word};
            end
            ld_d: begin
                load_data = rd_q;
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`include "rvx_cfg.svh"

module alu (
    input  rvx_pkg::alu_op_e     alu_op,
    input  logic [`RVX_XLEN-1:0] src1,
    input  logic [`RVX_XLEN-1:0] src2,
    output logic [`RVX_XLEN-1:0] alu_res,
    output logic                 cmp
);
    import rvx_pkg::*;

    logic [`RVX_XLEN-1:0] sum;
    logic [`RVX_XLEN-1:0] diff;
    logic [`RVX_XLEN-1:0] shl;
    logic [`RVX_XLEN-1:0] shl_w;
    logic                 src2_zero;

    assign sum       = src1 + src2;
    assign diff      = src1 - src2;
    assign shl       = src1 << src2[5:0];
    assign shl_w     = src1 << src2[4:0];  // 5-bit amount for the W form
    assign src2_zero = (src2 == '0);

    always_comb begin
        alu_res = '0;
        cmp     = 1'b0;
        case (alu_op)
            op_add: begin
                alu_res = sum;
            end
            op_addw: begin
                alu_res = {{(`RVX_XLEN-32){1'b0}}, sum[31:0]};
            end
            op_sub: begin
                alu_res = diff;
            end
            op_and: begin
                alu_res = src1 & src2;
            end
            op_or: begin
                alu_res = src1 | src2;
            end
            op_xor: begin
                alu_res = src1 ^ src2;
            end
            op_sll: begin
                alu_res = shl;
            end
            op_sllw: begin
                alu_res = {{(`RVX_XLEN-32){1'b0}}, shl_w[31:0]};
            end
            op_sra: begin
                alu_res = $signed(src1) >>> src2[5:0];
            end
            op_sltu: begin
                alu_res = {{(`RVX_XLEN-1){1'b0}}, (src1 < src2)};
            end
            op_mul: begin
                alu_res = src1 * src2;  // low half only
            end
            op_remu: begin
                alu_res = src2_zero ? src1 : (src1 % src2);
            end
            op_beq: begin
                alu_res = diff;
                cmp     = (diff == '0);
            end
            op_bne: begin
                alu_res = diff;
                cmp     = (diff != '0);
            end
            op_blt: begin
                alu_res = diff;
                cmp     = ($signed(src1) < $signed(src2));
            end
            op_pass: begin
                alu_res = src2;
            end
            default: begin
                alu_res = sum;
            end
        endcase
    end

endmodule

// ==== verilog/op_decoder.sv ====
`timescale 1ns/1ps
`include "rvx_cfg.svh"

module op_decoder (
    input  logic [31:0]          instr,
    input  logic [`RVX_XLEN-1:0] rs1_val,
    input  logic [`RVX_XLEN-1:0] rs2_val,
    output rvx_pkg::alu_op_e     alu_op,
    output logic [`RVX_XLEN-1:0] op_a,
    output logic [`RVX_XLEN-1:0] op_b,
    output rvx_pkg::load_kind_e  load_kind,
    output logic [4:0]           rd,
    output logic                 rd_we
);
    import rvx_pkg::*;

    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_lui       = 7'b0110111;

    localparam logic [1:0] sel_rs2   = 2'd0;
    localparam logic [1:0] sel_imm_i = 2'd1;
    localparam logic [1:0] sel_imm_u = 2'd2;

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`RVX_XLEN-1:0] imm_i;
    logic [`RVX_XLEN-1:0] imm_u;
    logic [1:0]           b_sel;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    assign imm_i = {{(`RVX_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {{(`RVX_XLEN-32){instr[31]}}, instr[31:12], 12'b0};  // sign extended like lui

    always_comb begin
        alu_op    = op_add;
        load_kind = ld_none;
        rd_we     = 1'b0;
        b_sel     = sel_rs2;
        case (opcode)
            opc_op: begin
                rd_we = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = op_add;
                    {7'h20, 3'b000}: alu_op = op_sub;
                    {7'h00, 3'b001}: alu_op = op_sll;
                    {7'h00, 3'b011}: alu_op = op_sltu;
                    {7'h00, 3'b100}: alu_op = op_xor;
                    {7'h20, 3'b101}: alu_op = op_sra;
                    {7'h00, 3'b110}: alu_op = op_or;
                    {7'h00, 3'b111}: alu_op = op_and;
                    {7'h01, 3'b000}: alu_op = op_mul;
                    {7'h01, 3'b111}: alu_op = op_remu;
                    default:         rd_we  = 1'b0;
                endcase
            end
            opc_op_imm: begin
                rd_we = 1'b1;
                b_sel = sel_imm_i;
                case (funct3)
                    3'b000: alu_op = op_add;
                    3'b011: alu_op = op_sltu;  // compares against sign extended imm
                    3'b100: alu_op = op_xor;
                    3'b110: alu_op = op_or;
                    3'b111: alu_op = op_and;
                    3'b001: begin
                        if (instr[31:26] == 6'b000000) begin
                            alu_op = op_sll;
                        end else begin
                            rd_we = 1'b0;
                        end
                    end
                    3'b101: begin
                        if (instr[31:26] == 6'b010000) begin
                            alu_op = op_sra;
                        end else begin
                            rd_we = 1'b0;
                        end
                    end
                    default: rd_we = 1'b0;
                endcase
            end
            opc_op_32: begin
                rd_we = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = op_addw;
                    {7'h00, 3'b001}: alu_op = op_sllw;
                    default:         rd_we  = 1'b0;
                endcase
            end
            opc_op_imm_32: begin
                rd_we = 1'b1;
                b_sel = sel_imm_i;
                case ({funct7, funct3})
                    {funct7, 3'b000}: alu_op = op_addw;  // addiw ignores funct7
                    {7'h00, 3'b001}:  alu_op = op_sllw;
                    default:          rd_we  = 1'b0;
                endcase
            end
            opc_load: begin
                b_sel = sel_imm_i;  // alu forms the address
                rd_we = 1'b1;
                case (funct3)
                    3'b100:  load_kind = ld_bu;
                    3'b110:  load_kind = ld_wu;
                    3'b011:  load_kind = ld_d;
                    default: rd_we     = 1'b0;
                endcase
            end
            opc_branch: begin
                case (funct3)
                    3'b000:  alu_op = op_beq;
                    3'b001:  alu_op = op_bne;
                    3'b100:  alu_op = op_blt;
                    default: alu_op = op_add;
                endcase
            end
            opc_lui: begin
                alu_op = op_pass;
                b_sel  = sel_imm_u;
                rd_we  = 1'b1;
            end
            default: rd_we = 1'b0;
        endcase
    end

    assign op_a = rs1_val;

    always_comb begin
        case (b_sel)
            sel_imm_i: op_b = imm_i;
            sel_imm_u: op_b = imm_u;
            default:   op_b = rs2_val;
        endcase
    end

endmodule

// ==== verilog/rvx_pkg.sv ====
`include "rvx_cfg.svh"

package rvx_pkg;

    typedef enum logic [3:0] {
        op_add,
        op_addw,  // zero extended low 32 bits
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_sllw,  // zero extended low 32 bits
        op_sra,
        op_sltu,
        op_mul,
        op_remu,
        op_beq,
        op_bne,
        op_blt,
        op_pass   // result is src2
    } alu_op_e;

    typedef enum logic [1:0] {
        ld_none,
        ld_bu,
        ld_wu,
        ld_d
    } load_kind_e;

    typedef struct packed {
        alu_op_e              alu_op;
        logic [`RVX_XLEN-1:0] op_a;
        logic [`RVX_XLEN-1:0] op_b;
        load_kind_e           load_kind;
        logic [4:0]           rd;
        logic                 rd_we;
    } ex_req_t;

    typedef struct packed {
        logic [`RVX_XLEN-1:0] alu_res;
        logic                 branch;
        load_kind_e           load_kind;
        logic [2:0]           byte_off;  // address bits 2:0 of a load
        logic [4:0]           rd;
        logic                 rd_we;
    } wb_t;

endpackage

// ==== verilog/rvx_cfg.svh ====
`ifndef RVX_CFG_SVH
`define RVX_CFG_SVH

// datapath width in bits
`define RVX_XLEN 64

// data memory size in doublewords
`define RVX_DMEM_DEPTH 256

// doubleword index width
`define RVX_DMEM_AW 8

`endif
